// File: design/panel_pkg.sv
package panel_pkg;

    // panel geometry
    localparam int PANEL_WIDTH = 32;
    localparam int PANEL_HEIGHT = 16;
    localparam int PANEL_HALFHEIGHT = 8;
    localparam int SUBPANELS = 2;
    localparam int BYTES_PER_PIXEL = 3;
    // one ram lane per half and colour
    localparam int LANES = SUBPANELS * BYTES_PER_PIXEL;
    // colour byte width, also the number of bit planes
    localparam int COLOR_BITS = 8;
    // lit cycles of plane 0, doubled per plane
    localparam int ON_BASE = 1;
    // read strobe to read data, address reg plus lane output reg
    localparam int READ_LATENCY = 2;

    // derived widths
    localparam int COL_BITS = $clog2(PANEL_WIDTH);
    localparam int ROW_BITS = $clog2(PANEL_HALFHEIGHT);
    localparam int Y_BITS = $clog2(PANEL_HEIGHT);
    localparam int SUB_BITS = $clog2(SUBPANELS);
    localparam int LANE_BITS = $clog2(LANES);
    localparam int PLANE_BITS = $clog2(COLOR_BITS);
    localparam int ON_BITS = $clog2(ON_BASE) + COLOR_BITS;
    // read pipe plus the pclk high phase of the last column
    localparam int DRAIN_CYCLES = READ_LATENCY + 1;
    localparam int DRAIN_BITS = $clog2(DRAIN_CYCLES);

    // COLOR_NONE is the illegal code, never stored
    typedef enum logic [1:0] {
        COLOR_RED   = 2'd0,
        COLOR_GREEN = 2'd1,
        COLOR_BLUE  = 2'd2,
        COLOR_NONE  = 2'd3
    } color_sel_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_DRAIN,
        ST_LATCH,
        ST_SHOW
    } scan_state_t;

    // one location in every lane
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
    } mem_read_addr_t;

    // lane index is subpanel * BYTES_PER_PIXEL + color
    typedef struct packed {
        logic [SUB_BITS-1:0] subpanel;
        mem_read_addr_t      addr;
        color_sel_t          color;
    } mem_write_addr_t;

    // lane 0 sits in the low byte
    typedef logic [LANES-1:0][COLOR_BITS-1:0] mem_read_data_t;

    // host write request
    typedef struct packed {
        logic [COL_BITS-1:0]   x;
        logic [Y_BITS-1:0]     y;
        color_sel_t            color;
        logic [COLOR_BITS-1:0] value;
    } pixel_write_t;

    typedef struct packed {
        logic                r0;
        logic                g0;
        logic                b0;
        logic                r1;
        logic                g1;
        logic                b1;
        logic                pclk;
        logic                lat;
        logic                oe_n;
        logic [ROW_BITS-1:0] row;
    } panel_pins_t;

endpackage

// File: design/mem_lane.sv
module mem_lane #(
    parameter int ADDR_BITS = 8,
    parameter int DW = 8
) (
    input  logic                 ClockA,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  logic [DW-1:0]        wr_data,
    input  logic                 rd_en,
    input  logic                 rst_n,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output logic [DW-1:0]        rd_data
);

    // one byte per pixel location of this lane
    logic [DW-1:0] mem [2**ADDR_BITS];

    // write port
    always_ff @(posedge ClockA) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, holds its value between strobes
    always_ff @(posedge ClockA) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: design/multimem.sv
module multimem (
    input  logic                       ClockA,
    input  logic                       rst_n,
    input  logic                       wr,
    input  panel_pkg::mem_write_addr_t wr_addr,
    input  logic [7:0]                 wr_data,
    input  logic                       rd_en,
    input  panel_pkg::mem_read_addr_t  rd_addr,
    output panel_pkg::mem_read_data_t  rd_data
);

    logic [panel_pkg::LANE_BITS-1:0] lane_idx;
    logic [panel_pkg::LANES-1:0]     we_dec;
    logic [panel_pkg::LANES-1:0]     we_q;
    panel_pkg::mem_read_addr_t       wr_addr_q;
    logic [7:0]                      wr_data_q;
    logic                            rd_en_q;
    panel_pkg::mem_read_addr_t       rd_addr_q;

    // lane = half * bytes per pixel + colour
    assign lane_idx = panel_pkg::LANE_BITS'(wr_addr.subpanel * panel_pkg::BYTES_PER_PIXEL
                                            + wr_addr.color);

    // one-hot lane enable, the illegal colour reaches no lane
    always_comb begin
        for (int i = 0; i < panel_pkg::LANES; i++) begin
            we_dec[i] = wr && (wr_addr.color != panel_pkg::COLOR_NONE)
                        && (lane_idx == panel_pkg::LANE_BITS'(i));
        end
    end

    // write enables and read strobe
    always_ff @(posedge ClockA) begin
        if (!rst_n) begin
            we_q    <= '0;
            rd_en_q <= 1'b0;
        end else begin
            we_q    <= we_dec;
            rd_en_q <= rd_en;
        end
    end

    // address and data stage shared by all lanes
    always_ff @(posedge ClockA) begin
        wr_addr_q <= wr_addr.addr;
        wr_data_q <= wr_data;
        rd_addr_q <= rd_addr;
    end

    for (genvar g = 0; g < panel_pkg::LANES; g++) begin : g_lane
        mem_lane #(
            .ADDR_BITS($bits(panel_pkg::mem_read_addr_t)),
            .DW       (panel_pkg::COLOR_BITS)
        ) u_lane (
            .ClockA (ClockA),
            .we     (we_q[g]),
            .wr_addr(wr_addr_q),
            .wr_data(wr_data_q),
            .rd_en  (rd_en_q),
            .rst_n  (rst_n),
            .rd_addr(rd_addr_q),
            .rd_data(rd_data[g])
        );
    end

endmodule

// File: design/pixel_loader.sv
module pixel_loader (
    input  logic                       ClockA,
    input  logic                       rst_n,
    input  panel_pkg::pixel_write_t    pixel,
    input  logic                       pixel_wr,
    output logic                       wr,
    output panel_pkg::mem_write_addr_t wr_addr,
    output logic [7:0]                 wr_data
);

    logic pixel_ok;

    // strobes carrying the illegal colour are dropped here
    assign pixel_ok = pixel_wr && (pixel.color != panel_pkg::COLOR_NONE);

    always_ff @(posedge ClockA) begin
        if (!rst_n) begin
            wr <= 1'b0;
        end else begin
            wr <= pixel_ok;
        end
    end

    // top bit of y picks the half, the rest is the row in that half
    always_ff @(posedge ClockA) begin
        if (pixel_ok) begin
            wr_addr.subpanel <= pixel.y[panel_pkg::Y_BITS-1 -: panel_pkg::SUB_BITS];
            wr_addr.addr.row <= pixel.y[panel_pkg::ROW_BITS-1:0];
            wr_addr.addr.col <= pixel.x;
            wr_addr.color    <= pixel.color;
            wr_data          <= pixel.value;
        end
    end

endmodule

// File: design/scan_timer.sv
module scan_timer (
    input  logic                             ClockA,
    input  logic                             rst_n,
    input  logic                             col_step,
    input  logic                             plane_step,
    input  logic                             on_load,
    input  logic                             on_run,
    output logic [panel_pkg::COL_BITS-1:0]   col,
    output logic                             last_col,
    output logic [panel_pkg::ROW_BITS-1:0]   row,
    output logic [panel_pkg::PLANE_BITS-1:0] plane,
    output logic                             last_plane,
    output logic                             on_done
);

    logic [panel_pkg::ON_BITS-1:0] on_cnt;

    assign last_col   = (col == panel_pkg::COL_BITS'(panel_pkg::PANEL_WIDTH - 1));
    assign last_plane = (plane == panel_pkg::PLANE_BITS'(panel_pkg::COLOR_BITS - 1));
    // zero marks the last lit cycle
    assign on_done    = (on_cnt == '0);

    always_ff @(posedge ClockA) begin
        if (!rst_n) begin
            col    <= '0;
            row    <= '0;
            plane  <= '0;
            on_cnt <= '0;
        end else begin
            // column wraps to 0 by width
            if (col_step) begin
                col <= col + 1'b1;
            end
            // row moves on when the plane wraps
            if (plane_step) begin
                plane <= plane + 1'b1;
                if (last_plane) begin
                    row <= row + 1'b1;
                end
            end
            // binary weighted on time, minus one for the done cycle
            if (on_load) begin
                on_cnt <= (panel_pkg::ON_BITS'(panel_pkg::ON_BASE) << plane)
                          - panel_pkg::ON_BITS'(1);
            end else if (on_run && !on_done) begin
                on_cnt <= on_cnt - 1'b1;
            end
        end
    end

endmodule

// File: design/scan_fsm.sv
module scan_fsm (
    input  logic                           ClockA,
    input  logic                           rst_n,
    input  logic                           scan_en,
    input  logic [panel_pkg::COL_BITS-1:0] col,
    input  logic                           last_col,
    input  logic [panel_pkg::ROW_BITS-1:0] row,
    input  logic                           on_done,
    output logic                           col_step,
    output logic                           plane_step,
    output logic                           on_load,
    output logic                           on_run,
    output logic                           rd_en,
    output panel_pkg::mem_read_addr_t      rd_addr,
    output logic                           latch,
    output logic                           show
);

    panel_pkg::scan_state_t state;
    panel_pkg::scan_state_t state_nx;
    // low phase reads, high phase steps the column
    logic phase;
    logic [panel_pkg::DRAIN_BITS-1:0] drain_cnt;

    always_ff @(posedge ClockA) begin
        if (!rst_n) begin
            state     <= panel_pkg::ST_IDLE;
            phase     <= 1'b0;
            drain_cnt <= '0;
        end else begin
            state     <= state_nx;
            phase     <= (state == panel_pkg::ST_SHIFT) ? ~phase : 1'b0;
            drain_cnt <= (state == panel_pkg::ST_DRAIN) ? drain_cnt + 1'b1 : '0;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            panel_pkg::ST_IDLE:
                if (scan_en) state_nx = panel_pkg::ST_SHIFT;
            // 32 columns at two cycles each
            panel_pkg::ST_SHIFT:
                if (phase && last_col) state_nx = panel_pkg::ST_DRAIN;
            // wait for the last column to clock out
            panel_pkg::ST_DRAIN:
                if (drain_cnt == panel_pkg::DRAIN_BITS'(panel_pkg::DRAIN_CYCLES - 1)) begin
                    state_nx = panel_pkg::ST_LATCH;
                end
            panel_pkg::ST_LATCH:
                state_nx = panel_pkg::ST_SHOW;
            // a falling scan_en only takes effect once the show is over
            panel_pkg::ST_SHOW:
                if (on_done) state_nx = scan_en ? panel_pkg::ST_SHIFT : panel_pkg::ST_IDLE;
            default:
                state_nx = panel_pkg::ST_IDLE;
        endcase
    end

    assign rd_en      = (state == panel_pkg::ST_SHIFT) && !phase;
    assign col_step   = (state == panel_pkg::ST_SHIFT) && phase;
    assign latch      = (state == panel_pkg::ST_LATCH);
    // on time loads while the row latches
    assign on_load    = latch;
    assign show       = (state == panel_pkg::ST_SHOW);
    assign on_run     = show;
    assign plane_step = show && on_done;

    assign rd_addr.row = row;
    assign rd_addr.col = col;

endmodule

// File: design/panel_shifter.sv
module panel_shifter (
    input  logic                             ClockA,
    input  logic                             rst_n,
    input  logic                             rd_en,
    input  logic [panel_pkg::PLANE_BITS-1:0] plane,
    input  panel_pkg::mem_read_data_t        rd_data,
    input  logic                             latch,
    input  logic                             show,
    input  logic [panel_pkg::ROW_BITS-1:0]   row,
    output panel_pkg::panel_pins_t           pins
);

    localparam int LAST = panel_pkg::READ_LATENCY - 1;

    // read strobe and its plane, lined up with rd_data
    logic [panel_pkg::READ_LATENCY-1:0]                           vld_d;
    logic [panel_pkg::READ_LATENCY-1:0][panel_pkg::PLANE_BITS-1:0] plane_d;
    // high during the low pclk phase
    logic strobe_q;
    logic [panel_pkg::LANES-1:0] bits_q;
    logic pclk_q;
    logic lat_q;
    logic oe_n_q;
    logic [panel_pkg::ROW_BITS-1:0] row_q;

    always_ff @(posedge ClockA) begin
        if (!rst_n) begin
            vld_d    <= '0;
            strobe_q <= 1'b0;
            pclk_q   <= 1'b0;
            lat_q    <= 1'b0;
            oe_n_q   <= 1'b1;
            row_q    <= '0;
        end else begin
            vld_d[0] <= rd_en;
            for (int i = 1; i < panel_pkg::READ_LATENCY; i++) begin
                vld_d[i] <= vld_d[i-1];
            end
            strobe_q <= vld_d[LAST];
            // rises one cycle after the colour bits settle
            pclk_q   <= strobe_q;
            lat_q    <= latch;
            oe_n_q   <= !show;
            // row address moves only on a latch
            if (latch) begin
                row_q <= row;
            end
        end
    end

    always_ff @(posedge ClockA) begin
        plane_d[0] <= plane;
        for (int i = 1; i < panel_pkg::READ_LATENCY; i++) begin
            plane_d[i] <= plane_d[i-1];
        end
        // pick the current bit plane from every lane
        if (vld_d[LAST]) begin
            for (int l = 0; l < panel_pkg::LANES; l++) begin
                bits_q[l] <= rd_data[l][plane_d[LAST]];
            end
        end
    end

    // lanes 0..2 upper half rgb, lanes 3..5 lower half rgb
    assign pins.r0   = bits_q[0];
    assign pins.g0   = bits_q[1];
    assign pins.b0   = bits_q[2];
    assign pins.r1   = bits_q[3];
    assign pins.g1   = bits_q[4];
    assign pins.b1   = bits_q[5];
    assign pins.pclk = pclk_q;
    assign pins.lat  = lat_q;
    assign pins.oe_n = oe_n_q;
    assign pins.row  = row_q;

endmodule

// File: design/panel_top.sv
module panel_top (
    input  logic                    ClockA,
    input  logic                    rst_n,
    input  panel_pkg::pixel_write_t pixel,
    input  logic                    pixel_wr,
    input  logic                    scan_en,
    output panel_pkg::panel_pins_t  pins
);

    // write path
    logic                       wr;
    panel_pkg::mem_write_addr_t wr_addr;
    logic [7:0]                 wr_data;
    // read path
    logic                       rd_en;
    panel_pkg::mem_read_addr_t  rd_addr;
    panel_pkg::mem_read_data_t  rd_data;
    // scan control
    logic                             col_step;
    logic                             plane_step;
    logic                             on_load;
    logic                             on_run;
    logic [panel_pkg::COL_BITS-1:0]   col;
    logic                             last_col;
    logic [panel_pkg::ROW_BITS-1:0]   row;
    logic [panel_pkg::PLANE_BITS-1:0] plane;
    logic                             on_done;
    logic                             latch;
    logic                             show;

    pixel_loader u_loader (
        .ClockA(ClockA), .rst_n(rst_n), .pixel(pixel), .pixel_wr(pixel_wr),
        .wr(wr), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    multimem u_mem (
        .ClockA(ClockA), .rst_n(rst_n), .wr(wr), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    // last_plane only steers the row inside the timer
    scan_timer u_timer (
        .ClockA(ClockA), .rst_n(rst_n), .col_step(col_step), .plane_step(plane_step),
        .on_load(on_load), .on_run(on_run), .col(col), .last_col(last_col), .row(row),
        .plane(plane), .last_plane(), .on_done(on_done)
    );

    scan_fsm u_fsm (
        .ClockA(ClockA), .rst_n(rst_n), .scan_en(scan_en), .col(col), .last_col(last_col),
        .row(row), .on_done(on_done), .col_step(col_step), .plane_step(plane_step),
        .on_load(on_load), .on_run(on_run), .rd_en(rd_en), .rd_addr(rd_addr),
        .latch(latch), .show(show)
    );

    panel_shifter u_shifter (
        .ClockA(ClockA), .rst_n(rst_n), .rd_en(rd_en), .plane(plane), .rd_data(rd_data),
        .latch(latch), .show(show), .row(row), .pins(pins)
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock (
    output logic ClockA,
    output logic rst_n
);

    // 100 unit period
    initial begin
        ClockA = 1'b0;
        forever #50 ClockA = ~ClockA;
    end

    // reset low for the first five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge ClockA);
        #10 rst_n = 1'b1;
    end

endmodule

// File: bench/panel_tb.sv
module panel_tb;

    // three frames of 6392 cycles, about 1900 write and idle cycles, then margin
    localparam int TIMEOUT_CYCLES = 25000;
    // 8 rows of 8 planes
    localparam int FRAME_LATCHES = panel_pkg::PANEL_HALFHEIGHT * panel_pkg::COLOR_BITS;

    logic                    ClockA;
    logic                    rst_n;
    panel_pkg::pixel_write_t pixel;
    logic                    pixel_wr;
    logic                    scan_en;
    panel_pkg::panel_pins_t  pins;

    // framebuffer model indexed by y, x, colour
    logic [7:0] fb_model [16][32][3];
    // set while the scan is stopped
    logic quiet;

    // pin monitor
    logic pclk_prev;
    logic oe_prev;
    int   col_cnt;
    int   latch_cnt;
    int   on_len;
    int   cycle_cnt = 0;

    // row and plane of the plane being shifted, and of the one on show
    logic [2:0] exp_row;
    logic [2:0] exp_plane;
    logic [2:0] show_row;
    logic [2:0] show_plane;
    logic [4:0] col_idx;
    logic [5:0] pin_bits;
    logic [5:0] exp_bits;
    int         on_expect;

    tb_clock u_clock (.ClockA(ClockA), .rst_n(rst_n));

    panel_top DUT (
        .ClockA(ClockA), .rst_n(rst_n), .pixel(pixel), .pixel_wr(pixel_wr),
        .scan_en(scan_en), .pins(pins)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge ClockA);
        #10;
    endtask

    // one strobe, the model only takes legal colours
    task automatic write_byte(input logic [4:0] x, input logic [3:0] y,
                              input panel_pkg::color_sel_t c, input logic [7:0] v);
        pixel.x     = x;
        pixel.y     = y;
        pixel.color = c;
        pixel.value = v;
        pixel_wr    = 1'b1;
        if (c != panel_pkg::COLOR_NONE) begin
            fb_model[y][x][c] = v;
        end
        next_cycle();
    endtask

    // idle once oe_n has stayed high for 10 cycles
    task automatic wait_idle();
        int high_run;
        high_run = 0;
        while (high_run < 10) begin
            next_cycle();
            high_run = pins.oe_n ? high_run + 1 : 0;
        end
    endtask

    task automatic wait_latches(input int count);
        while (latch_cnt < count) begin
            next_cycle();
        end
    endtask

    // latch k shows row k/8 mod 8 at plane k mod 8
    assign exp_row    = 3'((latch_cnt / panel_pkg::COLOR_BITS) % panel_pkg::PANEL_HALFHEIGHT);
    assign exp_plane  = 3'(latch_cnt % panel_pkg::COLOR_BITS);
    assign show_row   = 3'(((latch_cnt - 1) / panel_pkg::COLOR_BITS)
                           % panel_pkg::PANEL_HALFHEIGHT);
    assign show_plane = 3'((latch_cnt - 1) % panel_pkg::COLOR_BITS);
    assign on_expect  = panel_pkg::ON_BASE << show_plane;
    assign col_idx    = 5'(col_cnt);

    assign pin_bits = {pins.b1, pins.g1, pins.r1, pins.b0, pins.g0, pins.r0};
    assign exp_bits = {fb_model[{1'b1, exp_row}][col_idx][2][exp_plane],
                       fb_model[{1'b1, exp_row}][col_idx][1][exp_plane],
                       fb_model[{1'b1, exp_row}][col_idx][0][exp_plane],
                       fb_model[{1'b0, exp_row}][col_idx][2][exp_plane],
                       fb_model[{1'b0, exp_row}][col_idx][1][exp_plane],
                       fb_model[{1'b0, exp_row}][col_idx][0][exp_plane]};

    // columns since the last latch, latch count, length of the oe_n low window
    always @(posedge ClockA) begin
        if (!rst_n) begin
            pclk_prev <= 1'b0;
            oe_prev   <= 1'b1;
            col_cnt   <= 0;
            latch_cnt <= 0;
            on_len    <= 0;
        end else begin
            pclk_prev <= pins.pclk;
            oe_prev   <= pins.oe_n;
            if (pins.pclk && !pclk_prev) begin
                col_cnt <= col_cnt + 1;
            end
            if (pins.lat) begin
                col_cnt   <= 0;
                latch_cnt <= latch_cnt + 1;
            end
            on_len <= pins.oe_n ? 0 : on_len + 1;
        end
    end

    always @(posedge ClockA) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            fail_run("timeout: the scan did not finish within the cycle limit");
        end
    end

    // panel dark and still while the scan is stopped
    quiet_pins: assert property (@(posedge ClockA) disable iff (!rst_n)
        quiet |-> (!pins.pclk && !pins.lat && pins.oe_n))
    else fail_run($sformatf("[ERROR] pins.{pclk,lat,oe_n} got %h expected 1",
                  {$sampled(pins.pclk), $sampled(pins.lat), $sampled(pins.oe_n)}));

    // colour bits at each rising pclk
    pixel_bits: assert property (@(posedge ClockA) disable iff (!rst_n)
        (pins.pclk && !pclk_prev) |-> (pin_bits == exp_bits))
    else fail_run($sformatf("[ERROR] pins.{b1,g1,r1,b0,g0,r0} got %h expected %h",
                  $sampled(pin_bits), $sampled(exp_bits)));

    pulse_count: assert property (@(posedge ClockA) disable iff (!rst_n)
        pins.lat |-> (col_cnt == panel_pkg::PANEL_WIDTH))
    else fail_run($sformatf("[ERROR] pclk pulses per latch got %h expected %h",
                  $sampled(col_cnt), panel_pkg::PANEL_WIDTH));

    // blanked while latching or clocking
    blanking: assert property (@(posedge ClockA) disable iff (!rst_n)
        (pins.lat || pins.pclk || pclk_prev) |-> pins.oe_n)
    else fail_run($sformatf("[ERROR] pins.oe_n got %h expected 1", $sampled(pins.oe_n)));

    on_time: assert property (@(posedge ClockA) disable iff (!rst_n)
        (pins.oe_n && !oe_prev) |-> (on_len == on_expect))
    else fail_run($sformatf("[ERROR] oe_n low cycles got %h expected %h",
                  $sampled(on_len), $sampled(on_expect)));

    lit_row: assert property (@(posedge ClockA) disable iff (!rst_n)
        !pins.oe_n |-> (pins.row == show_row))
    else fail_run($sformatf("[ERROR] pins.row got %h expected %h",
                  $sampled(pins.row), $sampled(show_row)));

    initial begin
        pixel    = '0;
        pixel_wr = 1'b0;
        scan_en  = 1'b0;
        quiet    = 1'b1;
        void'($urandom(51445));
        wait (rst_n);
        next_cycle();

        // fill the whole framebuffer, illegal strobes mixed in
        for (int y = 0; y < panel_pkg::PANEL_HEIGHT; y++) begin
            for (int x = 0; x < panel_pkg::PANEL_WIDTH; x++) begin
                for (int c = 0; c < panel_pkg::BYTES_PER_PIXEL; c++) begin
                    if ($urandom_range(7) == 0) begin
                        write_byte(5'($urandom()), 4'($urandom()), panel_pkg::COLOR_NONE,
                                   8'($urandom()));
                    end
                    write_byte(5'(x), 4'(y), panel_pkg::color_sel_t'(2'(c)), 8'($urandom()));
                end
            end
        end
        pixel_wr = 1'b0;
        next_cycle();

        // two frames, then stop during the last show
        scan_en = 1'b1;
        quiet   = 1'b0;
        wait_latches(2 * FRAME_LATCHES);
        scan_en = 1'b0;
        wait_idle();
        quiet = 1'b1;

        // rewrite some bytes while stopped
        for (int i = 0; i < 100; i++) begin
            if (i % 8 == 7) begin
                write_byte(5'($urandom()), 4'($urandom()), panel_pkg::COLOR_NONE,
                           8'($urandom()));
            end
            write_byte(5'($urandom()), 4'($urandom()),
                       panel_pkg::color_sel_t'(2'($urandom_range(2))), 8'($urandom()));
        end
        pixel_wr = 1'b0;
        repeat (4) next_cycle();

        // one more frame with the new bytes
        scan_en = 1'b1;
        quiet   = 1'b0;
        wait_latches(3 * FRAME_LATCHES);
        scan_en = 1'b0;
        wait_idle();

        $display("sim passed");
        $finish;
    end

endmodule

// File: flist.f
design/panel_pkg.sv
design/mem_lane.sv
design/multimem.sv
design/pixel_loader.sv
design/scan_timer.sv
design/scan_fsm.sv
design/panel_shifter.sv
design/panel_top.sv
bench/tb_clock.sv
bench/panel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the panel testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module panel_tb \
        -f flist.f -o panel_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/panel_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "sim passed" <<< "$sim_out"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
